/* Makefile */
# Verilator flow for the APB floating-point unit
TOP := fpu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

# Exit status of the binary is the pass or fail of the run
sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* files.f */
verilog/fpu_pkg.sv
verilog/fpu_apb_regs.sv
verilog/fpu_unpack.sv
verilog/fpu_arith.sv
verilog/fpu_norm.sv
verilog/fpu_exc.sv
verilog/fpu_top.sv
sim/fpu_top_assert.sv
sim/fpu_tb.sv

/* sim/fpu_tb.sv */
`timescale 1ns/1ps
// Testbench of the APB floating-point unit
// Clock, reset, APB write/read tasks, LFSR operands
// Integer reference model, result-check assertions

module fpu_tb;
   import fpu_pkg::*;

   localparam int ADDR_W = 8;
   localparam int TMO    = 50;  // Cycles allowed for pready

   localparam logic [31:0] F_ONE = 32'h3F80_0000;
   localparam logic [31:0] F_INF = 32'h7F80_0000;

   logic              clk;
   logic              arst_n;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [ADDR_W-1:0] paddr;
   logic [31:0]       pwdata;
   logic [31:0]       prdata;
   logic              pready;
   logic              pslverr;

   logic [31:0] lfsr_q;
   // Values under check, set on a falling edge
   logic        chk_en;
   logic [31:0] chk_got;
   logic [31:0] chk_exp;
   string       chk_what;
   logic        err_en;
   logic        err_got;
   logic        err_exp;

   fpu_top #(.ADDR_W(ADDR_W)) u_dut (
      .clk(clk), .arst_n(arst_n),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
      .prdata(prdata), .pready(pready), .pslverr(pslverr)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;  // 40 ns period
   end

   //////////////////////////////
   // Checks
   //////////////////////////////
   read_matches: assert property (@(posedge clk) disable iff (!arst_n)
      chk_en |-> chk_got == chk_exp)
   else
   begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, chk_what, chk_got, chk_exp);
      $display("Errors found");
      $fatal(1, "Read check failed");
   end

   slverr_matches: assert property (@(posedge clk) disable iff (!arst_n)
      err_en |-> err_got == err_exp)
   else
   begin
      $display("Error at %0t ns: pslverr is %b, expected %b", $time, err_got, err_exp);
      $display("Errors found");
      $fatal(1, "Error response check failed");
   end

   //////////////////////////////
   // Reference model
   //////////////////////////////
   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic next_rand_bit();
      logic fb;
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      return fb;
   endfunction

   // Integer in -2047..2047
   function automatic int rand_int();
      int mag;
      mag = 0;
      for (int i = 0; i < 11; i++)
         mag = (mag << 1) | int'(next_rand_bit());
      return next_rand_bit() ? -mag : mag;
   endfunction

   // Exact encoding, magnitude below 2^24
   function automatic logic [31:0] int_to_float(input int v);
      logic        s;
      logic [31:0] mag;
      int          p;
      s   = (v < 0);
      mag = s ? 32'(-v) : 32'(v);
      if (mag == 0)
         return 32'd0;
      p = 0;
      for (int i = 0; i < 24; i++)
         if (mag[i])
            p = i;  // Top set bit
      return {s, 8'(127 + p), 23'(mag << (23 - p))};
   endfunction

   function automatic logic [5:0] exact_flags(input int v);
      exact_flags           = '0;
      exact_flags[FLG_ZERO] = (v == 0);  // Exact results raise nothing else
   endfunction

   // Zero product keeps the XOR of the signs
   function automatic logic [31:0] mul_word(input int a, input int b);
      if (a * b == 0)
         return {(a < 0) ^ (b < 0), 31'd0};
      return int_to_float(a * b);
   endfunction

   //////////////////////////////
   // APB driver
   //////////////////////////////
   task automatic wait_ready(output int stalls);
      stalls = 0;
      #1;  // Access phase settled
      while (!pready)
      begin
         @(negedge clk);
         #1;
         stalls++;
         if (stalls > TMO)
         begin
            $display("Errors found");
            $fatal(1, "pready stayed low for more than %0d cycles", TMO);
         end
      end
   endtask

   // Setup phase, then access phase until ready
   task automatic start_xfer(input logic [31:0] addr, input logic wr, input logic [31:0] data);
      @(negedge clk);
      chk_en  = 1'b0;
      err_en  = 1'b0;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = ADDR_W'(addr);
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
   endtask

   task automatic write_reg(input logic [31:0] addr, input logic [31:0] data, input logic slverr);
      int stalls;
      start_xfer(addr, 1'b1, data);
      wait_ready(stalls);
      err_got = pslverr;  // Judged at the completing edge
      err_exp = slverr;
      err_en  = 1'b1;
   endtask

   task automatic read_reg(input logic [31:0] addr, input logic slverr,
                           output logic [31:0] data, output int stalls);
      start_xfer(addr, 1'b0, 32'd0);
      wait_ready(stalls);
      data    = prdata;
      err_got = pslverr;
      err_exp = slverr;
      err_en  = 1'b1;
   endtask

   task automatic expect_value(input logic [31:0] got, input logic [31:0] exp, input string what);
      chk_got  = got;
      chk_exp  = exp;
      chk_what = what;
      chk_en   = 1'b1;
   endtask

   task automatic check_read(input logic [31:0] addr, input logic [31:0] exp, input string what);
      logic [31:0] data;
      int          stalls;
      read_reg(addr, 1'b0, data, stalls);
      expect_value(data, exp, what);
   endtask

   task automatic release_bus();
      @(negedge clk);
      chk_en  = 1'b0;
      err_en  = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // One operation, result read right after the command
   task automatic run_op(input logic [31:0] a, input logic [31:0] b, input fp_op_e op,
                         input logic [31:0] exp_word, input logic [5:0] exp_flags);
      write_reg(REG_OPA, a, 1'b0);
      write_reg(REG_OPB, b, 1'b0);
      write_reg(REG_CMD, 32'(op), 1'b0);
      check_read(REG_RESULT, exp_word, "RESULT");
      check_read(REG_FLAGS, 32'(exp_flags), "FLAGS");
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////
   initial
   begin
      int          a;
      int          b;
      logic [31:0] data;
      int          stalls;
      lfsr_q   = 32'h2702_749d;
      arst_n   = 1'b0;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      chk_en   = 1'b0;
      chk_got  = '0;
      chk_exp  = '0;
      chk_what = "";
      err_en   = 1'b0;
      err_got  = 1'b0;
      err_exp  = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      // Reset state
      @(negedge clk);
      expect_value(32'(pready), 32'd1, "pready after reset");
      check_read(REG_RESULT, 32'd0, "RESULT after reset");
      check_read(REG_FLAGS, 32'd0, "FLAGS after reset");
      check_read(REG_STICKY, 32'd0, "STICKY after reset");

      // Single add/sub, then equal operands
      for (int i = 0; i < 12; i++)
      begin
         a = rand_int();
         b = rand_int();
         run_op(int_to_float(a), int_to_float(b), OP_ADD, int_to_float(a + b), exact_flags(a + b));
         run_op(int_to_float(a), int_to_float(b), OP_SUB, int_to_float(a - b), exact_flags(a - b));
      end
      a = rand_int();
      run_op(int_to_float(a), int_to_float(a), OP_SUB, 32'd0, exact_flags(0));
      run_op(int_to_float(a), int_to_float(-a), OP_ADD, 32'd0, exact_flags(0));

      // Two commands in flight, sticky holds both flag sets
      for (int i = 0; i < 8; i++)
      begin
         a = (i == 3) ? 5 : rand_int();
         b = (i == 3) ? 5 : rand_int();
         write_reg(REG_STICKY, 32'd0, 1'b0);
         write_reg(REG_OPA, int_to_float(a), 1'b0);
         write_reg(REG_OPB, int_to_float(b), 1'b0);
         write_reg(REG_CMD, 32'(OP_ADD), 1'b0);
         write_reg(REG_CMD, 32'(OP_SUB), 1'b0);  // Back to back
         check_read(REG_RESULT, int_to_float(a - b), "RESULT of second");
         check_read(REG_FLAGS, 32'(exact_flags(a - b)), "FLAGS of second");
         check_read(REG_STICKY, 32'(exact_flags(a + b) | exact_flags(a - b)), "STICKY of pair");
      end

      // Multiply, zero operands included
      for (int i = 0; i < 12; i++)
      begin
         a = rand_int();
         b = rand_int();
         run_op(int_to_float(a), int_to_float(b), OP_MUL, mul_word(a, b), exact_flags(a * b));
      end
      run_op(32'd0, int_to_float(-9), OP_MUL, mul_word(0, -9), exact_flags(0));
      run_op(int_to_float(-9), 32'd0, OP_MUL, mul_word(-9, 0), exact_flags(0));

      // Rounding near 1.0
      run_op(F_ONE, 32'h3380_0000, OP_ADD, F_ONE, 6'h10);         // Tie, lsb even stays
      run_op(F_ONE, 32'h3440_0000, OP_ADD, 32'h3F80_0002, 6'h10); // Tie, lsb odd goes up
      run_op(F_ONE, 32'h33C0_0000, OP_ADD, 32'h3F80_0001, 6'h10); // Above half

      // Special operands
      run_op(F_INF, F_INF, OP_SUB, QNAN, 6'h01);
      run_op(F_INF, 32'd0, OP_MUL, QNAN, 6'h01);
      run_op(F_INF, F_ONE, OP_ADD, F_INF, 6'h20);
      run_op(32'h7F00_0000, 32'h4080_0000, OP_MUL, F_INF, 6'h32);  // OF, IX, INF
      run_op(32'h0D80_0000, 32'h0D80_0000, OP_MUL, 32'd0, 6'h1C);  // UF, ZERO, IX

      // Read stall right after a command
      write_reg(REG_OPA, int_to_float(3), 1'b0);
      write_reg(REG_OPB, int_to_float(-4), 1'b0);
      write_reg(REG_CMD, 32'(OP_MUL), 1'b0);
      read_reg(REG_RESULT, 1'b0, data, stalls);
      expect_value(data, int_to_float(-12), "RESULT after stall");
      release_bus();
      expect_value(32'(stalls > 0), 32'd1, "read stall seen");

      // Sticky accumulate and clear
      write_reg(REG_STICKY, 32'hFFFF_FFFF, 1'b0);
      run_op(F_ONE, 32'h3380_0000, OP_ADD, F_ONE, 6'h10);
      run_op(F_INF, F_ONE, OP_ADD, F_INF, 6'h20);
      check_read(REG_STICKY, 32'h30, "STICKY accumulated");
      write_reg(REG_STICKY, 32'd0, 1'b0);
      check_read(REG_STICKY, 32'd0, "STICKY after clear");

      // Rejected accesses leave RESULT alone, a started add would give 5
      run_op(int_to_float(7), int_to_float(-2), OP_SUB, int_to_float(9), exact_flags(9));
      write_reg(REG_CMD, 32'd3, 1'b1);                // Bad opcode
      write_reg(REG_RESULT, 32'h1234_5678, 1'b1);     // Read only
      write_reg(32'h18, 32'd0, 1'b1);                 // Unmapped
      read_reg(32'h1C, 1'b1, data, stalls);
      check_read(REG_RESULT, int_to_float(9), "RESULT after rejected accesses");

      release_bus();
      repeat (2) @(negedge clk);
      $display("No errors");
      $finish;
   end

endmodule

/* sim/fpu_top_assert.sv */
`timescale 1ns/1ps
// Bound checks on the FPU top level
// Result word against the IV, INF and OF flags
// APB pready and pslverr rules

module fpu_top_assert #(
   parameter int ADDR_W = 8
) (
   input logic              clk,
   input logic              arst_n,
   input logic              psel,
   input logic              penable,
   input logic              pwrite,
   input logic [ADDR_W-1:0] paddr,
   input logic              pready,
   input logic              pslverr,
   input logic              op_valid,
   input logic              s1_valid,
   input logic              s2_valid,
   input logic              res_valid,
   input logic [31:0]       res_word,
   input logic [5:0]        res_flags
);
   import fpu_pkg::*;

   logic status_addr;
   logic busy;

   assign status_addr = (32'(paddr) == REG_RESULT) | (32'(paddr) == REG_FLAGS)
                      | (32'(paddr) == REG_STICKY);
   assign busy        = op_valid | s1_valid | s2_valid | res_valid;  // Any stage occupied

   //////////////////////////////
   // Result word vs flags
   //////////////////////////////
   iv_gives_qnan: assert property (@(posedge clk) disable iff (!arst_n)
      res_valid && res_flags[FLG_IV] |-> res_word == QNAN)
      else $error("Invalid result is not the quiet NaN");

   inf_gives_inf: assert property (@(posedge clk) disable iff (!arst_n)
      res_valid && res_flags[FLG_INF] |-> res_word[30:23] == 8'hFF && res_word[22:0] == '0)
      else $error("Infinity flag without an infinite result word");

   of_implies_ix: assert property (@(posedge clk) disable iff (!arst_n)
      res_valid && res_flags[FLG_OF] |-> res_flags[FLG_IX])
      else $error("Overflow flag without the inexact flag");

   //////////////////////////////
   // APB side
   //////////////////////////////
   stall_only_on_status: assert property (@(posedge clk) disable iff (!arst_n)
      !pready |-> psel && penable && !pwrite && status_addr && busy)
      else $error("pready low outside a status read with work in flight");

   slverr_on_completion: assert property (@(posedge clk) disable iff (!arst_n)
      pslverr |-> psel && penable && pready)
      else $error("pslverr high outside a completing access");

endmodule

bind fpu_top fpu_top_assert #(.ADDR_W(ADDR_W)) u_assert (
   .clk(clk), .arst_n(arst_n),
   .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
   .pready(pready), .pslverr(pslverr),
   .op_valid(op_valid), .s1_valid(s1_valid), .s2_valid(s2_valid),
   .res_valid(res_valid), .res_word(res_word), .res_flags(res_flags)
);

/* verilog/fpu_apb_regs.sv */
`timescale 1ns/1ps
// APB slave of the FPU
// Operand, command, result, flag and sticky flag registers
// Opcode check, in-flight count, read stall on status registers

module fpu_apb_regs #(
   parameter int ADDR_W = 8
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [ADDR_W-1:0] paddr,
   input  logic [31:0]       pwdata,
   output logic [31:0]       prdata,
   output logic              pready,
   output logic              pslverr,
   input  logic              res_valid,
   input  logic [31:0]       res_word,
   input  logic [5:0]        res_flags,
   output logic              op_valid,
   output fpu_pkg::fp_op_e   op,
   output logic [31:0]       opa,
   output logic [31:0]       opb
);
   import fpu_pkg::*;

   logic [31:0] addr;
   logic        sel_opa;
   logic        sel_opb;
   logic        sel_cmd;
   logic        sel_res;
   logic        sel_flg;
   logic        sel_sty;
   logic        unmapped;
   logic        status_rd;
   logic        xfer;
   logic        wr;
   logic        cmd_ok;
   logic        cmd_go;
   logic [1:0]  inflight_q;  // At most two in flight
   logic [31:0] result_q;
   logic [5:0]  flags_q;
   logic [5:0]  sticky_q;

   //////////////////////////////
   // Address decode
   //////////////////////////////
   assign addr     = 32'(paddr);
   assign sel_opa  = (addr == REG_OPA);
   assign sel_opb  = (addr == REG_OPB);
   assign sel_cmd  = (addr == REG_CMD);
   assign sel_res  = (addr == REG_RESULT);
   assign sel_flg  = (addr == REG_FLAGS);
   assign sel_sty  = (addr == REG_STICKY);
   assign unmapped = ~(sel_opa | sel_opb | sel_cmd | sel_res | sel_flg | sel_sty);

   // Status reads wait for an empty pipeline
   assign status_rd = psel & penable & ~pwrite & (sel_res | sel_flg | sel_sty);
   assign pready    = ~(status_rd & (inflight_q != 2'd0));

   assign xfer   = psel & penable & pready;
   assign wr     = xfer & pwrite;
   assign cmd_ok = (pwdata <= 32'(OP_MUL));  // Codes 0..2 only
   assign cmd_go = wr & sel_cmd & cmd_ok;

   // Error in the completing cycle only
   assign pslverr = xfer & (unmapped
                            | (pwrite & (sel_res | sel_flg))
                            | (pwrite & sel_cmd & ~cmd_ok));

   always_comb
   begin
      prdata = '0;
      if (sel_opa)      prdata = opa;
      else if (sel_opb) prdata = opb;
      else if (sel_res) prdata = result_q;
      else if (sel_flg) prdata = 32'(flags_q);
      else if (sel_sty) prdata = 32'(sticky_q);
   end

   //////////////////////////////
   // Registers
   //////////////////////////////
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         opa        <= '0;
         opb        <= '0;
         op         <= OP_ADD;
         op_valid   <= 1'b0;
         inflight_q <= '0;
         result_q   <= '0;
         flags_q    <= '0;
         sticky_q   <= '0;
      end
      else
      begin
         op_valid <= cmd_go;  // One-cycle start pulse
         if (wr & sel_opa) opa <= pwdata;
         if (wr & sel_opb) opb <= pwdata;
         if (cmd_go)       op  <= fp_op_e'(pwdata[1:0]);

         case ({cmd_go, res_valid})
            2'b10:   inflight_q <= inflight_q + 2'd1;
            2'b01:   inflight_q <= inflight_q - 2'd1;
            default: inflight_q <= inflight_q;
         endcase

         if (res_valid)
         begin
            result_q <= res_word;
            flags_q  <= res_flags;
         end
         // Clear wins, then the new flags join
         sticky_q <= ((wr & sel_sty) ? 6'd0 : sticky_q) | (res_valid ? res_flags : 6'd0);
      end
   end

endmodule

/* verilog/fpu_arith.sv */
`timescale 1ns/1ps
// Pipeline stage 2 of the FPU
// Mantissa add/subtract with sign resolution, or 24x24 multiply
// Result mantissa has its hidden-bit weight at bit 46

module fpu_arith (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            in_valid,
   input  fpu_pkg::fp_op_e in_op,
   input  logic            in_sign_a,
   input  logic            in_sign_b,
   input  logic            in_inf_a,
   input  logic            in_inf_b,
   input  logic            in_zero_a,
   input  logic            in_zero_b,
   input  logic [26:0]     mant_a,
   input  logic [26:0]     mant_b,
   input  logic [9:0]      in_exp_base,
   output logic            out_valid,
   output fpu_pkg::fp_op_e out_op,
   output logic            res_sign,
   output logic [47:0]     sum_mant,
   output logic [9:0]      exp_base,
   output logic            sign_a,
   output logic            sign_b,
   output logic            inf_a,
   output logic            inf_b,
   output logic            zero_a,
   output logic            zero_b
);
   import fpu_pkg::*;

   logic        eff_sub;
   logic        a_ge_b;
   logic [27:0] mag;
   logic [47:0] prod;
   logic [47:0] sum_nx;
   logic        sign_nx;

   always_comb
   begin
      eff_sub = in_sign_a ^ in_sign_b;
      a_ge_b  = (mant_a >= mant_b);
      prod    = mant_a[26:3] * mant_b[26:3];
      mag     = '0;
      if (!eff_sub)
         mag = {1'b0, mant_a} + {1'b0, mant_b};
      else if (a_ge_b)
         mag = {1'b0, mant_a} - {1'b0, mant_b};
      else
         mag = {1'b0, mant_b} - {1'b0, mant_a};

      if (in_op == OP_MUL)
      begin
         sum_nx  = prod;
         sign_nx = in_sign_a ^ in_sign_b;
      end
      else
      begin
         sum_nx = {mag, 20'd0};  // Align hidden bit to 46
         if (!eff_sub)
            sign_nx = in_sign_a;
         else if (mant_a == mant_b)
            sign_nx = in_sign_a & in_sign_b;  // x - x is +0
         else
            sign_nx = a_ge_b ? in_sign_a : in_sign_b;  // Larger magnitude
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         out_valid <= 1'b0;
      else
         out_valid <= in_valid;
   end

   always_ff @(posedge clk)
   begin
      out_op   <= in_op;
      res_sign <= sign_nx;
      sum_mant <= sum_nx;
      exp_base <= in_exp_base;
      sign_a   <= in_sign_a;  // Class bits ride along
      sign_b   <= in_sign_b;
      inf_a    <= in_inf_a;
      inf_b    <= in_inf_b;
      zero_a   <= in_zero_a;
      zero_b   <= in_zero_b;
   end

endmodule

/* verilog/fpu_exc.sv */
`timescale 1ns/1ps
// Pipeline stage 4 of the FPU, combinational
// Invalid and infinity detection, IEEE flags
// Final result word with forced NaN, infinity or zero

module fpu_exc (
   input  logic            in_valid,
   input  fpu_pkg::fp_op_e op,
   input  logic            res_sign,
   input  logic [23:0]     mant_norm,
   input  logic [7:0]      exp_res,
   input  logic            mant_rounded,
   input  logic            exp_of,
   input  logic            exp_uf,
   input  logic            sign_a,
   input  logic            sign_b,
   input  logic            inf_a,
   input  logic            inf_b,
   input  logic            zero_a,
   input  logic            zero_b,
   output logic            res_valid,
   output logic [31:0]     res_word,
   output logic [5:0]      res_flags
);
   import fpu_pkg::*;

   logic mant_zero;
   logic op_inf;
   logic iv;
   logic inf_res;
   logic of;
   logic uf;
   logic zero;
   logic ix;
   logic inf_sign;

   assign mant_zero = (mant_norm == '0);
   assign op_inf    = inf_a | inf_b;  // Arithmetic path meaningless then

   //////////////////////////////
   // Invalid and infinite results
   //////////////////////////////
   always_comb
   begin
      if (op == OP_MUL)
      begin
         iv       = (inf_a & zero_b) | (inf_b & zero_a);  // Inf times zero
         inf_res  = (inf_a & ~zero_b) | (inf_b & ~zero_a);
         inf_sign = res_sign;
      end
      else
      begin
         iv       = inf_a & inf_b & (sign_a ^ sign_b);  // Sub already folded in sign_b
         inf_res  = (inf_a ^ inf_b) | (inf_a & inf_b & ~(sign_a ^ sign_b));
         inf_sign = inf_a ? sign_a : sign_b;
      end
   end

   // Flags
   assign of   = exp_of & ~mant_zero & ~op_inf;
   assign uf   = exp_uf & mant_rounded & ~op_inf;
   assign ix   = (mant_rounded & ~op_inf) | of;
   assign zero = (mant_zero | uf) & ~iv & ~inf_res;

   assign res_valid = in_valid;

   always_comb
   begin
      res_flags           = '0;
      res_flags[FLG_IV]   = iv;
      res_flags[FLG_OF]   = of;
      res_flags[FLG_UF]   = uf;
      res_flags[FLG_ZERO] = zero;
      res_flags[FLG_IX]   = ix;
      res_flags[FLG_INF]  = inf_res | of;

      if (iv)
         res_word = QNAN;
      else if (inf_res)
         res_word = {inf_sign, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
      else if (of)
         res_word = {res_sign, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
      else if (zero)
         res_word = {res_sign, 31'd0};  // Signed zero
      else
         res_word = {res_sign, exp_res, mant_norm[MANT_W-1:0]};
   end

endmodule

/* verilog/fpu_norm.sv */
`timescale 1ns/1ps
// Pipeline stage 3 of the FPU
// Leading-one normalization, round to nearest even
// Exponent overflow and underflow detection

module fpu_norm (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            in_valid,
   input  fpu_pkg::fp_op_e in_op,
   input  logic            in_res_sign,
   input  logic [47:0]     sum_mant,
   input  logic [9:0]      in_exp_base,
   input  logic            in_sign_a,
   input  logic            in_sign_b,
   input  logic            in_inf_a,
   input  logic            in_inf_b,
   input  logic            in_zero_a,
   input  logic            in_zero_b,
   output logic            out_valid,
   output fpu_pkg::fp_op_e out_op,
   output logic            res_sign,
   output logic [23:0]     mant_norm,
   output logic [7:0]      exp_res,
   output logic            mant_rounded,
   output logic            exp_of,
   output logic            exp_uf,
   output logic            sign_a,
   output logic            sign_b,
   output logic            inf_a,
   output logic            inf_b,
   output logic            zero_a,
   output logic            zero_b
);
   logic [5:0]        lz;
   logic              is_zero;
   logic [47:0]       m_sh;
   logic              guard;
   logic              sticky;
   logic [24:0]       m_rnd;
   logic signed [9:0] e_pre;
   logic signed [9:0] e_fin;
   logic              of_nx;
   logic              uf_nx;

   // Leading zero count, 48 when empty
   function automatic logic [5:0] lzc48(input logic [47:0] v);
      lzc48 = 6'd48;
      for (int i = 0; i < 48; i++)
         if (v[i])
            lzc48 = 6'(47 - i);
   endfunction

   //////////////////////////////
   // Normalize and round
   //////////////////////////////
   always_comb
   begin
      lz      = lzc48(sum_mant);
      is_zero = (sum_mant == '0);
      m_sh    = sum_mant << lz;  // Leading one to bit 47
      guard   = m_sh[23];
      sticky  = |m_sh[22:0];
      // Round up on more than half, or exact half with odd lsb
      m_rnd   = {1'b0, m_sh[47:24]} + 25'(guard & (sticky | m_sh[24]));
      e_pre   = $signed(in_exp_base) + 10'sd1 - $signed({4'd0, lz});
      e_fin   = e_pre + $signed({9'd0, m_rnd[24]});  // Round carry
      of_nx   = ~is_zero & (e_fin > 10'sd254);
      uf_nx   = ~is_zero & (e_fin < 10'sd1);
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         out_valid <= 1'b0;
      else
         out_valid <= in_valid;
   end

   always_ff @(posedge clk)
   begin
      out_op       <= in_op;
      res_sign     <= in_res_sign;
      mant_norm    <= m_rnd[24] ? m_rnd[24:1] : m_rnd[23:0];
      exp_res      <= is_zero ? 8'd0 : e_fin[7:0];
      mant_rounded <= guard | sticky | uf_nx;  // Flush drops everything
      exp_of       <= of_nx;
      exp_uf       <= uf_nx;
      sign_a       <= in_sign_a;
      sign_b       <= in_sign_b;
      inf_a        <= in_inf_a;
      inf_b        <= in_inf_b;
      zero_a       <= in_zero_a;
      zero_b       <= in_zero_b;
   end

endmodule

/* verilog/fpu_pkg.sv */
// Shared definitions of the APB floating-point unit
// Opcode enum, register map, flag bit positions, float field widths

package fpu_pkg;

   // Opcodes written to the command register
   typedef enum logic [1:0]
   {
      OP_ADD = 2'd0,
      OP_SUB = 2'd1,
      OP_MUL = 2'd2
   } fp_op_e;

   //////////////////////////////
   // Register map, byte offsets
   //////////////////////////////
   localparam logic [31:0] REG_OPA    = 32'h00;
   localparam logic [31:0] REG_OPB    = 32'h04;
   localparam logic [31:0] REG_CMD    = 32'h08; // Write only
   localparam logic [31:0] REG_RESULT = 32'h0C; // Read only
   localparam logic [31:0] REG_FLAGS  = 32'h10; // Read only
   localparam logic [31:0] REG_STICKY = 32'h14; // Write clears

   // Bit positions in the 6-bit flag word
   localparam int FLG_IV   = 0;
   localparam int FLG_OF   = 1;
   localparam int FLG_UF   = 2;
   localparam int FLG_ZERO = 3;
   localparam int FLG_IX   = 4;
   localparam int FLG_INF  = 5;

   // Single precision fields
   localparam int EXP_W    = 8;
   localparam int MANT_W   = 23;
   localparam int EXP_BIAS = 127;

   localparam logic [31:0] QNAN = 32'h7FC0_0000; // Canonical quiet NaN

endpackage

/* verilog/fpu_top.sv */
`timescale 1ns/1ps
// Top level of the APB floating-point unit
// APB register block followed by the four pipeline stages

module fpu_top #(
   parameter int ADDR_W = 8
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [ADDR_W-1:0] paddr,
   input  logic [31:0]       pwdata,
   output logic [31:0]       prdata,
   output logic              pready,
   output logic              pslverr
);
   import fpu_pkg::*;

   // Register block to stage 1
   logic        op_valid;
   fp_op_e      op;
   logic [31:0] opa;
   logic [31:0] opb;

   // Stage 1 to stage 2
   logic        s1_valid;
   fp_op_e      s1_op;
   logic        s1_sign_a, s1_sign_b, s1_inf_a, s1_inf_b, s1_zero_a, s1_zero_b;
   logic [26:0] s1_mant_a;
   logic [26:0] s1_mant_b;
   logic [9:0]  s1_exp;

   // Stage 2 to stage 3
   logic        s2_valid;
   fp_op_e      s2_op;
   logic        s2_res_sign;
   logic [47:0] s2_mant;
   logic [9:0]  s2_exp;
   logic        s2_sign_a, s2_sign_b, s2_inf_a, s2_inf_b, s2_zero_a, s2_zero_b;

   // Stage 3 to stage 4
   logic        s3_valid;
   fp_op_e      s3_op;
   logic        s3_res_sign;
   logic [23:0] s3_mant;
   logic [7:0]  s3_exp;
   logic        s3_rounded, s3_of, s3_uf;
   logic        s3_sign_a, s3_sign_b, s3_inf_a, s3_inf_b, s3_zero_a, s3_zero_b;

   // Stage 4 back to the register block
   logic        res_valid;
   logic [31:0] res_word;
   logic [5:0]  res_flags;

   fpu_apb_regs #(.ADDR_W(ADDR_W)) u_regs (
      .clk(clk), .arst_n(arst_n),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
      .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .res_valid(res_valid), .res_word(res_word), .res_flags(res_flags),
      .op_valid(op_valid), .op(op), .opa(opa), .opb(opb)
   );

   fpu_unpack u_unpack (
      .clk(clk), .arst_n(arst_n),
      .in_valid(op_valid), .in_op(op), .opa(opa), .opb(opb),
      .out_valid(s1_valid), .out_op(s1_op), .sign_a(s1_sign_a), .sign_b(s1_sign_b),
      .inf_a(s1_inf_a), .inf_b(s1_inf_b), .zero_a(s1_zero_a), .zero_b(s1_zero_b),
      .mant_a(s1_mant_a), .mant_b(s1_mant_b), .exp_base(s1_exp)
   );

   fpu_arith u_arith (
      .clk(clk), .arst_n(arst_n),
      .in_valid(s1_valid), .in_op(s1_op), .in_sign_a(s1_sign_a), .in_sign_b(s1_sign_b),
      .in_inf_a(s1_inf_a), .in_inf_b(s1_inf_b), .in_zero_a(s1_zero_a), .in_zero_b(s1_zero_b),
      .mant_a(s1_mant_a), .mant_b(s1_mant_b), .in_exp_base(s1_exp),
      .out_valid(s2_valid), .out_op(s2_op), .res_sign(s2_res_sign),
      .sum_mant(s2_mant), .exp_base(s2_exp), .sign_a(s2_sign_a), .sign_b(s2_sign_b),
      .inf_a(s2_inf_a), .inf_b(s2_inf_b), .zero_a(s2_zero_a), .zero_b(s2_zero_b)
   );

   fpu_norm u_norm (
      .clk(clk), .arst_n(arst_n),
      .in_valid(s2_valid), .in_op(s2_op), .in_res_sign(s2_res_sign),
      .sum_mant(s2_mant), .in_exp_base(s2_exp),
      .in_sign_a(s2_sign_a), .in_sign_b(s2_sign_b), .in_inf_a(s2_inf_a), .in_inf_b(s2_inf_b),
      .in_zero_a(s2_zero_a), .in_zero_b(s2_zero_b),
      .out_valid(s3_valid), .out_op(s3_op), .res_sign(s3_res_sign),
      .mant_norm(s3_mant), .exp_res(s3_exp), .mant_rounded(s3_rounded),
      .exp_of(s3_of), .exp_uf(s3_uf), .sign_a(s3_sign_a), .sign_b(s3_sign_b),
      .inf_a(s3_inf_a), .inf_b(s3_inf_b), .zero_a(s3_zero_a), .zero_b(s3_zero_b)
   );

   fpu_exc u_exc (
      .in_valid(s3_valid), .op(s3_op), .res_sign(s3_res_sign),
      .mant_norm(s3_mant), .exp_res(s3_exp), .mant_rounded(s3_rounded),
      .exp_of(s3_of), .exp_uf(s3_uf), .sign_a(s3_sign_a), .sign_b(s3_sign_b),
      .inf_a(s3_inf_a), .inf_b(s3_inf_b), .zero_a(s3_zero_a), .zero_b(s3_zero_b),
      .res_valid(res_valid), .res_word(res_word), .res_flags(res_flags)
   );

endmodule

/* verilog/fpu_unpack.sv */
`timescale 1ns/1ps
// Pipeline stage 1 of the FPU
// Field split, operand class, denormal flush
// Exponent alignment for add/sub, exponent sum for mul

module fpu_unpack (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            in_valid,
   input  fpu_pkg::fp_op_e in_op,
   input  logic [31:0]     opa,
   input  logic [31:0]     opb,
   output logic            out_valid,
   output fpu_pkg::fp_op_e out_op,
   output logic            sign_a,
   output logic            sign_b,
   output logic            inf_a,
   output logic            inf_b,
   output logic            zero_a,
   output logic            zero_b,
   output logic [26:0]     mant_a,
   output logic [26:0]     mant_b,
   output logic [9:0]      exp_base
);
   import fpu_pkg::*;

   logic [EXP_W-1:0] ea;
   logic [EXP_W-1:0] eb;
   logic             za;
   logic             zb;
   logic [26:0]      ma_raw;
   logic [26:0]      mb_raw;
   logic             a_big;
   logic [EXP_W-1:0] ediff;
   logic [9:0]       exp_nx;

   // Right shift keeping guard, round and a sticky lsb
   function automatic logic [26:0] align(input logic [26:0] m, input logic [EXP_W-1:0] sh);
      logic [53:0] ext;
      ext   = {m, 27'd0} >> ((sh > 8'd27) ? 8'd27 : sh);
      align = {ext[53:28], |ext[27:0]};
   endfunction

   assign ea = opa[30:23];
   assign eb = opb[30:23];
   assign za = (ea == '0);  // Denormals flushed
   assign zb = (eb == '0);

   // Hidden bit on top, three extra bits below
   assign ma_raw = za ? 27'd0 : {1'b1, opa[MANT_W-1:0], 3'b000};
   assign mb_raw = zb ? 27'd0 : {1'b1, opb[MANT_W-1:0], 3'b000};

   assign a_big  = (ea >= eb);
   assign ediff  = a_big ? (ea - eb) : (eb - ea);
   assign exp_nx = (in_op == OP_MUL) ? (10'(ea) + 10'(eb) - 10'(EXP_BIAS))
                                     : 10'(a_big ? ea : eb);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         out_valid <= 1'b0;
      else
         out_valid <= in_valid;
   end

   // Payload
   always_ff @(posedge clk)
   begin
      out_op   <= in_op;
      sign_a   <= opa[31];
      sign_b   <= opb[31] ^ (in_op == OP_SUB);  // Sub becomes add
      inf_a    <= (ea == '1);
      inf_b    <= (eb == '1);
      zero_a   <= za;
      zero_b   <= zb;
      exp_base <= exp_nx;
      if (in_op == OP_MUL)
      begin
         mant_a <= ma_raw;  // No alignment for mul
         mant_b <= mb_raw;
      end
      else
      begin
         mant_a <= a_big ? ma_raw : align(ma_raw, ediff);
         mant_b <= a_big ? align(mb_raw, ediff) : mb_raw;
      end
   end

endmodule
